// File: tb.f
hdl/bus_pkg.sv
hdl/obi_req_stage.sv
hdl/axil_issue_stage.sv
hdl/axil_resp_stage.sv
hdl/obi_axil_bridge.sv
hdl/core_bus_unit.sv
bench/core_bus_unit_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and judge the result from the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f tb.f --top-module core_bus_unit_tb -o core_bus_unit_sim \
	&& ./obj_dir/core_bus_unit_sim > sim.log 2>&1 \
	|| { echo "Build or run error, see sim.log"; exit 1; }

cat sim.log
grep -qx "Simulation passed" sim.log \
	&& { echo "RESULT: PASS"; exit 0; } \
	|| { echo "RESULT: FAIL"; exit 1; }

// File: bench/core_bus_unit_tb.sv
`timescale 1ns/1ps

module core_bus_unit_tb
	import bus_pkg::*;
;

	localparam int CLK_PERIOD = 20;
	localparam int SAMPLE_DELAY = 5;
	localparam int RESET_CYCLES = 10;
	localparam int WAIT_LIMIT = 60;
	localparam logic [31:0] SEED = 32'h12bf;

	localparam int SIG_INSTR_GNT = 0;
	localparam int SIG_DATA_GNT = 1;
	localparam int SIG_INSTR_RVALID = 2;
	localparam int SIG_DATA_RVALID = 3;
	localparam int SIG_PAUSE_ACK = 4;

	typedef struct {
		bit    is_data;
		bit    we;
		addr_t addr;
		strb_t be;
		data_t wdata;
		data_t exp;
	} row_t;

	logic  clk = 1'b0;
	logic  rst_n;
	logic  pause_req;
	logic  pause_ack;
	logic  instr_req;
	logic  instr_gnt;
	addr_t instr_addr;
	logic  instr_rvalid;
	data_t instr_rdata;
	logic  data_req;
	logic  data_gnt;
	addr_t data_addr;
	logic  data_we;
	strb_t data_be;
	data_t data_wdata;
	logic  data_rvalid;
	data_t data_rdata;

	// Bit 0 is the instruction port, bit 1 the data port
	logic [1:0] awvalid_m;
	logic [1:0] awready_m = '0;
	logic [1:0] wvalid_m;
	logic [1:0] wready_m = '0;
	logic [1:0] bvalid_m = '0;
	logic [1:0] bready_m;
	logic [1:0] arvalid_m;
	logic [1:0] arready_m = '0;
	logic [1:0] rvalid_m = '0;
	logic [1:0] rready_m;
	addr_t      awaddr_m [2];
	addr_t      araddr_m [2];
	data_t      wdata_m [2];
	strb_t      wstrb_m [2];
	data_t      rdata_m [2] = '{default: '0};

	// Memory model state
	logic [1:0] aw_fire = '0;
	logic [1:0] w_fire = '0;
	logic [1:0] ar_fire = '0;
	logic [1:0] b_fire = '0;
	logic [1:0] r_fire = '0;
	logic       in_reset = 1'b1;
	logic [1:0] have_aw;
	logic [1:0] have_w;
	logic [1:0] have_ar;
	int         aw_wait [2];
	int         w_wait [2];
	int         ar_wait [2];
	addr_t      aw_addr_q [2];
	addr_t      ar_addr_q [2];
	data_t      w_data_q [2];
	strb_t      w_strb_q [2];
	data_t      mem [0:63];

	row_t  rows[$];
	data_t shadow [0:63];
	int    checks = 0;
	int    errors = 0;
	int    timeouts = 0;
	int    instr_grants = 0;
	int    instr_returns = 0;
	int    data_grants = 0;
	int    data_returns = 0;

	core_bus_unit dut0 (
		.clk_i               (clk),
		.rst_n_i             (rst_n),
		.pause_req_i         (pause_req),
		.pause_ack_o         (pause_ack),
		.instr_req_i         (instr_req),
		.instr_gnt_o         (instr_gnt),
		.instr_addr_i        (instr_addr),
		.instr_rvalid_o      (instr_rvalid),
		.instr_rdata_o       (instr_rdata),
		.data_req_i          (data_req),
		.data_gnt_o          (data_gnt),
		.data_addr_i         (data_addr),
		.data_we_i           (data_we),
		.data_be_i           (data_be),
		.data_wdata_i        (data_wdata),
		.data_rvalid_o       (data_rvalid),
		.data_rdata_o        (data_rdata),
		.inst_axil_awaddr_o  (awaddr_m[0]),
		.inst_axil_awvalid_o (awvalid_m[0]),
		.inst_axil_awready_i (awready_m[0]),
		.inst_axil_wdata_o   (wdata_m[0]),
		.inst_axil_wstrb_o   (wstrb_m[0]),
		.inst_axil_wvalid_o  (wvalid_m[0]),
		.inst_axil_wready_i  (wready_m[0]),
		.inst_axil_bvalid_i  (bvalid_m[0]),
		.inst_axil_bready_o  (bready_m[0]),
		.inst_axil_araddr_o  (araddr_m[0]),
		.inst_axil_arvalid_o (arvalid_m[0]),
		.inst_axil_arready_i (arready_m[0]),
		.inst_axil_rdata_i   (rdata_m[0]),
		.inst_axil_rvalid_i  (rvalid_m[0]),
		.inst_axil_rready_o  (rready_m[0]),
		.data_axil_awaddr_o  (awaddr_m[1]),
		.data_axil_awvalid_o (awvalid_m[1]),
		.data_axil_awready_i (awready_m[1]),
		.data_axil_wdata_o   (wdata_m[1]),
		.data_axil_wstrb_o   (wstrb_m[1]),
		.data_axil_wvalid_o  (wvalid_m[1]),
		.data_axil_wready_i  (wready_m[1]),
		.data_axil_bvalid_i  (bvalid_m[1]),
		.data_axil_bready_o  (bready_m[1]),
		.data_axil_araddr_o  (araddr_m[1]),
		.data_axil_arvalid_o (arvalid_m[1]),
		.data_axil_arready_i (arready_m[1]),
		.data_axil_rdata_i   (rdata_m[1]),
		.data_axil_rvalid_i  (rvalid_m[1]),
		.data_axil_rready_o  (rready_m[1])
	);

	initial begin
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Instruction memory contents
	function automatic data_t rom_word(addr_t a);
		return {a[15:0], a[31:16]} ^ 32'h1357_9bdf;
	endfunction

	// Power-up contents of the data memory
	function automatic data_t fill_word(addr_t a);
		return (a * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
	endfunction

	function automatic data_t merge(data_t old, data_t wd, strb_t be);
		data_t res;
		res = old;
		for (int i = 0; i < 4; i++) begin
			if (be[i]) begin
				res[8*i +: 8] = wd[8*i +: 8];
			end
		end
		return res;
	endfunction

	function automatic logic probe(int sel);
		case (sel)
			SIG_INSTR_GNT:    return instr_gnt;
			SIG_DATA_GNT:     return data_gnt;
			SIG_INSTR_RVALID: return instr_rvalid;
			SIG_DATA_RVALID:  return data_rvalid;
			default:          return pause_ack;
		endcase
	endfunction

	// Handshakes seen at the rising edge, used on the next falling edge
	always @(posedge clk) begin
		aw_fire  <= awvalid_m & awready_m;
		w_fire   <= wvalid_m & wready_m;
		ar_fire  <= arvalid_m & arready_m;
		b_fire   <= bvalid_m & bready_m;
		r_fire   <= rvalid_m & rready_m;
		in_reset <= !rst_n;
	end

	always @(posedge clk) begin
		if (rst_n) begin
			if (instr_req && instr_gnt) instr_grants++;
			if (data_req && data_gnt) data_grants++;
			if (instr_rvalid) instr_returns++;
			if (data_rvalid) data_returns++;
		end
	end

	// AXI-lite slaves, each ready comes 0 to 3 cycles after its valid
	always @(negedge clk) begin
		for (int p = 0; p < 2; p++) begin
			if (in_reset) begin
				awready_m[p] = 1'b0;
				wready_m[p]  = 1'b0;
				arready_m[p] = 1'b0;
				bvalid_m[p]  = 1'b0;
				rvalid_m[p]  = 1'b0;
				have_aw[p]   = 1'b0;
				have_w[p]    = 1'b0;
				have_ar[p]   = 1'b0;
				aw_wait[p]   = $urandom % 4;
				w_wait[p]    = $urandom % 4;
				ar_wait[p]   = $urandom % 4;
			end
			else begin
				if (aw_fire[p]) begin
					awready_m[p] = 1'b0;
					aw_addr_q[p] = awaddr_m[p];
					have_aw[p]   = 1'b1;
					aw_wait[p]   = $urandom % 4;
				end
				else if (awvalid_m[p] && !awready_m[p]) begin
					if (aw_wait[p] == 0) awready_m[p] = 1'b1;
					else aw_wait[p]--;
				end
				if (w_fire[p]) begin
					wready_m[p] = 1'b0;
					w_data_q[p] = wdata_m[p];
					w_strb_q[p] = wstrb_m[p];
					have_w[p]   = 1'b1;
					w_wait[p]   = $urandom % 4;
				end
				else if (wvalid_m[p] && !wready_m[p]) begin
					if (w_wait[p] == 0) wready_m[p] = 1'b1;
					else w_wait[p]--;
				end
				if (ar_fire[p]) begin
					arready_m[p] = 1'b0;
					ar_addr_q[p] = araddr_m[p];
					have_ar[p]   = 1'b1;
					ar_wait[p]   = $urandom % 4;
				end
				else if (arvalid_m[p] && !arready_m[p]) begin
					if (ar_wait[p] == 0) arready_m[p] = 1'b1;
					else ar_wait[p]--;
				end

				if (b_fire[p]) bvalid_m[p] = 1'b0;
				if (have_aw[p] && have_w[p] && !bvalid_m[p]) begin
					if (p == 1) begin
						mem[aw_addr_q[p][7:2]] = merge(mem[aw_addr_q[p][7:2]], w_data_q[p],
							w_strb_q[p]);
					end
					have_aw[p]  = 1'b0;
					have_w[p]   = 1'b0;
					bvalid_m[p] = 1'b1;
				end

				if (r_fire[p]) rvalid_m[p] = 1'b0;
				if (have_ar[p] && !rvalid_m[p]) begin
					rdata_m[p]  = (p == 0) ? rom_word(ar_addr_q[p]) : mem[ar_addr_q[p][7:2]];
					have_ar[p]  = 1'b0;
					rvalid_m[p] = 1'b1;
				end
			end
		end
		if (in_reset) begin
			for (int i = 0; i < 64; i++) begin
				mem[i] = fill_word(addr_t'(4 * i));
			end
		end
	end

	task automatic check_value(string name, data_t got, data_t exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("ERR %0t ns %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// The fetch port only reads, its write channels stay idle
	always @(posedge clk) begin
		if (rst_n) begin
			check_value("inst_axil_awvalid_o", data_t'(awvalid_m[0]), '0);
			check_value("inst_axil_wvalid_o", data_t'(wvalid_m[0]), '0);
			if (arvalid_m[0]) begin
				check_value("inst_axil_wdata_o", wdata_m[0], '0);
				check_value("inst_axil_wstrb_o", data_t'(wstrb_m[0]), '0);
			end
		end
	end

	// Samples once per cycle in the low phase, returns on a falling edge
	task automatic wait_for(int sel, logic level, string what, output data_t rdata);
		logic seen;
		seen = 1'b0;
		rdata = '0;
		for (int n = 0; n < WAIT_LIMIT && !seen; n++) begin
			#SAMPLE_DELAY;
			seen = (probe(sel) === level);
			rdata = (sel == SIG_INSTR_RVALID) ? instr_rdata : data_rdata;
			@(negedge clk);
		end
		if (!seen) begin
			timeouts++;
			$display("Timeout at %0t ns while waiting for %s", $time, what);
		end
	endtask

	task automatic add_row(bit is_data, bit we, addr_t a, strb_t be, data_t wd);
		row_t r;
		r.is_data = is_data;
		r.we      = we;
		r.addr    = a;
		r.be      = be;
		r.wdata   = wd;
		if (!is_data) begin
			r.exp = rom_word(a);
		end
		else if (we) begin
			shadow[a[7:2]] = merge(shadow[a[7:2]], wd, be);
			r.exp = '0;
		end
		else begin
			r.exp = shadow[a[7:2]];
		end
		rows.push_back(r);
	endtask

	task automatic build_table();
		for (int i = 0; i < 64; i++) begin
			shadow[i] = fill_word(addr_t'(4 * i));
		end
		add_row(0, 0, 32'h0000_1000, 4'h0, 32'h0);
		add_row(0, 0, 32'h0000_1004, 4'h0, 32'h0);
		add_row(1, 1, 32'h0000_0040, 4'hf, 32'h1122_3344);
		add_row(1, 1, 32'h0000_0040, 4'h2, 32'h0000_aa00);
		add_row(1, 1, 32'h0000_0040, 4'h9, 32'hcc00_00dd);
		add_row(1, 0, 32'h0000_0040, 4'hf, 32'h0);
		add_row(0, 0, 32'h8000_2ffc, 4'h0, 32'h0);
		add_row(1, 0, 32'h0000_0080, 4'hf, 32'h0);
		add_row(1, 1, 32'h0000_0084, 4'hc, 32'hbeef_0000);
		add_row(1, 0, 32'h0000_0084, 4'hf, 32'h0);
		add_row(1, 1, 32'h0000_0044, 4'h1, 32'h0000_0077);
		add_row(0, 0, 32'h0000_103c, 4'h0, 32'h0);
		add_row(1, 0, 32'h0000_0044, 4'hf, 32'h0);
		add_row(1, 1, 32'h0000_00fc, 4'h6, 32'h0012_3400);
		add_row(1, 0, 32'h0000_00fc, 4'hf, 32'h0);
		add_row(1, 0, 32'h0000_0040, 4'hf, 32'h0);
	endtask

	task automatic apply_row(row_t r);
		data_t got;
		if (r.is_data) begin
			data_req   = 1'b1;
			data_addr  = r.addr;
			data_we    = r.we;
			data_be    = r.be;
			data_wdata = r.wdata;
		end
		else begin
			instr_req  = 1'b1;
			instr_addr = r.addr;
		end
		wait_for(r.is_data ? SIG_DATA_GNT : SIG_INSTR_GNT, 1'b1, "gnt", got);
		data_req  = 1'b0;
		instr_req = 1'b0;
		wait_for(r.is_data ? SIG_DATA_RVALID : SIG_INSTR_RVALID, 1'b1, "rvalid", got);
		if (!r.we) begin
			check_value(r.is_data ? "data_rdata_o" : "instr_rdata_o", got, r.exp);
		end
	endtask

	// A load in flight and a fetch waiting when the pause comes
	task automatic run_pause_test();
		data_t got;
		logic  load_seen;
		logic  acked;
		load_seen = 1'b0;
		acked = 1'b0;
		data_req  = 1'b1;
		data_addr = 32'h0000_0040;
		data_we   = 1'b0;
		data_be   = 4'hf;
		wait_for(SIG_DATA_GNT, 1'b1, "data gnt before pause", got);
		data_req   = 1'b0;
		pause_req  = 1'b1;
		instr_req  = 1'b1;
		instr_addr = 32'h0000_1010;
		for (int n = 0; n < WAIT_LIMIT && !acked; n++) begin
			#SAMPLE_DELAY;
			check_value("instr_gnt_o", data_t'(instr_gnt), '0);
			check_value("data_gnt_o", data_t'(data_gnt), '0);
			if (data_rvalid) begin
				load_seen = 1'b1;
				check_value("data_rdata_o", data_rdata, shadow[6'h10]);
			end
			if (pause_ack) begin
				acked = 1'b1;
				check_value("data_rvalid_o count", data_t'(data_returns), data_t'(data_grants));
				check_value("instr_rvalid_o count", data_t'(instr_returns),
					data_t'(instr_grants));
			end
			@(negedge clk);
		end
		if (!acked) begin
			timeouts++;
			$display("Timeout at %0t ns, pause_ack_o never rose", $time);
		end
		check_value("data_rvalid_o before pause_ack_o", data_t'(load_seen), 32'd1);
		pause_req = 1'b0;
		wait_for(SIG_INSTR_GNT, 1'b1, "instr gnt after release", got);
		instr_req = 1'b0;
		wait_for(SIG_PAUSE_ACK, 1'b0, "pause_ack_o to fall", got);
		wait_for(SIG_INSTR_RVALID, 1'b1, "instr rvalid after release", got);
		check_value("instr_rdata_o", got, rom_word(32'h0000_1010));
	endtask

	initial begin
		void'($urandom(SEED));
		rst_n      = 1'b0;
		pause_req  = 1'b0;
		instr_req  = 1'b0;
		instr_addr = '0;
		data_req   = 1'b0;
		data_addr  = '0;
		data_we    = 1'b0;
		data_be    = '0;
		data_wdata = '0;
		build_table();

		repeat (RESET_CYCLES - 1) @(negedge clk);
		#SAMPLE_DELAY;
		// No grant while reset is held, even with the pause low
		check_value("instr_gnt_o", data_t'(instr_gnt), '0);
		check_value("data_gnt_o", data_t'(data_gnt), '0);
		@(negedge clk);
		rst_n = 1'b1;
		#SAMPLE_DELAY;
		check_value("axil awvalid_o", data_t'(awvalid_m), '0);
		check_value("axil wvalid_o", data_t'(wvalid_m), '0);
		check_value("axil arvalid_o", data_t'(arvalid_m), '0);
		check_value("rvalid_o", data_t'({instr_rvalid, data_rvalid}), '0);
		check_value("pause_ack_o", data_t'(pause_ack), '0);
		@(negedge clk);

		foreach (rows[i]) begin
			apply_row(rows[i]);
		end
		run_pause_test();

		check_value("instr_rvalid_o pulses", data_t'(instr_returns), data_t'(instr_grants));
		check_value("data_rvalid_o pulses", data_t'(data_returns), data_t'(data_grants));
		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Simulation passed");
		end
		else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: hdl/core_bus_unit.sv
`timescale 1ns/1ps

module core_bus_unit
	import bus_pkg::*;
#(
	parameter int ADDR_WIDTH = bus_pkg::ADDR_WIDTH,
	parameter int DATA_WIDTH = bus_pkg::DATA_WIDTH
) (
	input  logic  clk_i,
	input  logic  rst_n_i,

	input  logic  pause_req_i,
	output logic  pause_ack_o,

	// Instruction fetch, read only
	input  logic  instr_req_i,
	output logic  instr_gnt_o,
	input  addr_t instr_addr_i,
	output logic  instr_rvalid_o,
	output data_t instr_rdata_o,

	// Load and store
	input  logic  data_req_i,
	output logic  data_gnt_o,
	input  addr_t data_addr_i,
	input  logic  data_we_i,
	input  strb_t data_be_i,
	input  data_t data_wdata_i,
	output logic  data_rvalid_o,
	output data_t data_rdata_o,

	output addr_t inst_axil_awaddr_o,
	output logic  inst_axil_awvalid_o,
	input  logic  inst_axil_awready_i,
	output data_t inst_axil_wdata_o,
	output strb_t inst_axil_wstrb_o,
	output logic  inst_axil_wvalid_o,
	input  logic  inst_axil_wready_i,
	input  logic  inst_axil_bvalid_i,
	output logic  inst_axil_bready_o,
	output addr_t inst_axil_araddr_o,
	output logic  inst_axil_arvalid_o,
	input  logic  inst_axil_arready_i,
	input  data_t inst_axil_rdata_i,
	input  logic  inst_axil_rvalid_i,
	output logic  inst_axil_rready_o,

	output addr_t data_axil_awaddr_o,
	output logic  data_axil_awvalid_o,
	input  logic  data_axil_awready_i,
	output data_t data_axil_wdata_o,
	output strb_t data_axil_wstrb_o,
	output logic  data_axil_wvalid_o,
	input  logic  data_axil_wready_i,
	input  logic  data_axil_bvalid_i,
	output logic  data_axil_bready_o,
	output addr_t data_axil_araddr_o,
	output logic  data_axil_arvalid_o,
	input  logic  data_axil_arready_i,
	input  data_t data_axil_rdata_i,
	input  logic  data_axil_rvalid_i,
	output logic  data_axil_rready_o
);

	logic inst_pause_ack;
	logic data_pause_ack;

	// Fetch never writes
	obi_axil_bridge #(
		.ADDR_WIDTH (ADDR_WIDTH),
		.DATA_WIDTH (DATA_WIDTH)
	) inst_bridge (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.pause_req_i (pause_req_i),
		.pause_ack_o (inst_pause_ack),
		.req_i       (instr_req_i),
		.gnt_o       (instr_gnt_o),
		.addr_i      (instr_addr_i),
		.we_i        (1'b0),
		.be_i        ('0),
		.wdata_i     ('0),
		.rvalid_o    (instr_rvalid_o),
		.rdata_o     (instr_rdata_o),
		.awaddr_o    (inst_axil_awaddr_o),
		.awvalid_o   (inst_axil_awvalid_o),
		.awready_i   (inst_axil_awready_i),
		.wdata_o     (inst_axil_wdata_o),
		.wstrb_o     (inst_axil_wstrb_o),
		.wvalid_o    (inst_axil_wvalid_o),
		.wready_i    (inst_axil_wready_i),
		.bvalid_i    (inst_axil_bvalid_i),
		.bready_o    (inst_axil_bready_o),
		.araddr_o    (inst_axil_araddr_o),
		.arvalid_o   (inst_axil_arvalid_o),
		.arready_i   (inst_axil_arready_i),
		.rdata_i     (inst_axil_rdata_i),
		.rvalid_i    (inst_axil_rvalid_i),
		.rready_o    (inst_axil_rready_o)
	);

	obi_axil_bridge #(
		.ADDR_WIDTH (ADDR_WIDTH),
		.DATA_WIDTH (DATA_WIDTH)
	) data_bridge (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.pause_req_i (pause_req_i),
		.pause_ack_o (data_pause_ack),
		.req_i       (data_req_i),
		.gnt_o       (data_gnt_o),
		.addr_i      (data_addr_i),
		.we_i        (data_we_i),
		.be_i        (data_be_i),
		.wdata_i     (data_wdata_i),
		.rvalid_o    (data_rvalid_o),
		.rdata_o     (data_rdata_o),
		.awaddr_o    (data_axil_awaddr_o),
		.awvalid_o   (data_axil_awvalid_o),
		.awready_i   (data_axil_awready_i),
		.wdata_o     (data_axil_wdata_o),
		.wstrb_o     (data_axil_wstrb_o),
		.wvalid_o    (data_axil_wvalid_o),
		.wready_i    (data_axil_wready_i),
		.bvalid_i    (data_axil_bvalid_i),
		.bready_o    (data_axil_bready_o),
		.araddr_o    (data_axil_araddr_o),
		.arvalid_o   (data_axil_arvalid_o),
		.arready_i   (data_axil_arready_i),
		.rdata_i     (data_axil_rdata_i),
		.rvalid_i    (data_axil_rvalid_i),
		.rready_o    (data_axil_rready_o)
	);

	// Ack rises when both are paused and falls once both have resumed
	always_comb begin
		if (pause_req_i) begin
			pause_ack_o = inst_pause_ack && data_pause_ack;
		end
		else begin
			pause_ack_o = inst_pause_ack || data_pause_ack;
		end
	end

endmodule

// File: hdl/obi_axil_bridge.sv
`timescale 1ns/1ps

module obi_axil_bridge
	import bus_pkg::*;
#(
	parameter int ADDR_WIDTH = bus_pkg::ADDR_WIDTH,
	parameter int DATA_WIDTH = bus_pkg::DATA_WIDTH
) (
	input  logic  clk_i,
	input  logic  rst_n_i,

	input  logic  pause_req_i,
	output logic  pause_ack_o,

	// OBI slave side
	input  logic  req_i,
	output logic  gnt_o,
	input  addr_t addr_i,
	input  logic  we_i,
	input  strb_t be_i,
	input  data_t wdata_i,
	output logic  rvalid_o,
	output data_t rdata_o,

	// AXI-lite master side
	output addr_t awaddr_o,
	output logic  awvalid_o,
	input  logic  awready_i,
	output data_t wdata_o,
	output strb_t wstrb_o,
	output logic  wvalid_o,
	input  logic  wready_i,
	input  logic  bvalid_i,
	output logic  bready_o,
	output addr_t araddr_o,
	output logic  arvalid_o,
	input  logic  arready_i,
	input  data_t rdata_i,
	input  logic  rvalid_i,
	output logic  rready_o
);

	logic  hold_valid;
	logic  take;
	addr_t hold_addr;
	logic  hold_we;
	strb_t hold_be;
	data_t hold_wdata;
	logic  start;
	logic  start_we;
	logic  busy;
	addr_t axi_addr;

	obi_req_stage #(
		.ADDR_WIDTH (ADDR_WIDTH),
		.DATA_WIDTH (DATA_WIDTH)
	) req_stage (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.req_i        (req_i),
		.gnt_o        (gnt_o),
		.addr_i       (addr_i),
		.we_i         (we_i),
		.be_i         (be_i),
		.wdata_i      (wdata_i),
		.pause_i      (pause_req_i),
		.hold_valid_o (hold_valid),
		.take_i       (take),
		.hold_addr_o  (hold_addr),
		.hold_we_o    (hold_we),
		.hold_be_o    (hold_be),
		.hold_wdata_o (hold_wdata)
	);

	axil_issue_stage issue_stage (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.hold_valid_i (hold_valid),
		.take_o       (take),
		.hold_addr_i  (hold_addr),
		.hold_we_i    (hold_we),
		.hold_be_i    (hold_be),
		.hold_wdata_i (hold_wdata),
		.busy_i       (busy),
		.start_o      (start),
		.start_we_o   (start_we),
		.awvalid_o    (awvalid_o),
		.awready_i    (awready_i),
		.wvalid_o     (wvalid_o),
		.wready_i     (wready_i),
		.arvalid_o    (arvalid_o),
		.arready_i    (arready_i),
		.axi_addr_o   (axi_addr),
		.wdata_o      (wdata_o),
		.wstrb_o      (wstrb_o)
	);

	axil_resp_stage resp_stage (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.start_i      (start),
		.start_we_i   (start_we),
		.busy_o       (busy),
		.bvalid_i     (bvalid_i),
		.bready_o     (bready_o),
		.rvalid_axi_i (rvalid_i),
		.rready_o     (rready_o),
		.rdata_axi_i  (rdata_i),
		.rvalid_o     (rvalid_o),
		.rdata_o      (rdata_o)
	);

	// Write and read addresses share one register
	assign awaddr_o = axi_addr;
	assign araddr_o = axi_addr;

	// Idle once nothing is held, outstanding or still being returned
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			pause_ack_o <= 1'b0;
		end
		else begin
			pause_ack_o <= pause_req_i && !hold_valid && !busy && !rvalid_o;
		end
	end

endmodule

// File: hdl/axil_resp_stage.sv
`timescale 1ns/1ps

module axil_resp_stage
	import bus_pkg::*;
(
	input  logic  clk_i,
	input  logic  rst_n_i,

	input  logic  start_i,
	input  logic  start_we_i,
	output logic  busy_o,

	input  logic  bvalid_i,
	output logic  bready_o,
	input  logic  rvalid_axi_i,
	output logic  rready_o,
	input  data_t rdata_axi_i,

	output logic  rvalid_o,
	output data_t rdata_o
);

	logic  busy;
	logic  pending_we;
	logic  b_done;
	logic  r_done;
	logic  resp_valid;
	data_t resp_data;

	// Only the response matching the outstanding transaction is accepted
	assign bready_o = busy && pending_we;
	assign rready_o = busy && !pending_we;

	assign b_done = bready_o && bvalid_i;
	assign r_done = rready_o && rvalid_axi_i;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			busy       <= 1'b0;
			pending_we <= 1'b0;
			resp_valid <= 1'b0;
		end
		else begin
			resp_valid <= b_done || r_done;

			if (start_i) begin
				busy       <= 1'b1;
				pending_we <= start_we_i;
			end
			else if (b_done || r_done) begin
				busy <= 1'b0;
			end
		end
	end

	// Write responses leave the last read word in place
	always_ff @(posedge clk_i) begin
		if (r_done) begin
			resp_data <= rdata_axi_i;
		end
	end

	assign busy_o   = busy;
	assign rvalid_o = resp_valid;
	assign rdata_o  = resp_data;

endmodule

// File: hdl/axil_issue_stage.sv
`timescale 1ns/1ps

module axil_issue_stage
	import bus_pkg::*;
(
	input  logic  clk_i,
	input  logic  rst_n_i,

	input  logic  hold_valid_i,
	output logic  take_o,
	input  addr_t hold_addr_i,
	input  logic  hold_we_i,
	input  strb_t hold_be_i,
	input  data_t hold_wdata_i,

	input  logic  busy_i,
	output logic  start_o,
	output logic  start_we_o,

	output logic  awvalid_o,
	input  logic  awready_i,
	output logic  wvalid_o,
	input  logic  wready_i,
	output logic  arvalid_o,
	input  logic  arready_i,

	output addr_t axi_addr_o,
	output data_t wdata_o,
	output strb_t wstrb_o
);

	issue_state_e state;
	issue_state_e state_next;

	addr_t axi_addr;
	data_t wdata;
	strb_t wstrb;

	// One transaction on the bus at a time
	assign take_o     = hold_valid_i && (state == ISSUE_IDLE) && !busy_i;
	assign start_o    = take_o;
	assign start_we_o = hold_we_i;

	always_comb begin
		state_next = state;

		case (state)
			ISSUE_IDLE: begin
				if (take_o) begin
					state_next = hold_we_i ? ISSUE_SEND_AW_W : ISSUE_SEND_AR;
				end
			end
			ISSUE_SEND_AW_W: begin
				// AW and W may be accepted in either order
				if (awready_i && wready_i) begin
					state_next = ISSUE_IDLE;
				end
				else if (awready_i) begin
					state_next = ISSUE_WAIT_W;
				end
				else if (wready_i) begin
					state_next = ISSUE_WAIT_AW;
				end
			end
			ISSUE_WAIT_AW: begin
				if (awready_i) begin
					state_next = ISSUE_IDLE;
				end
			end
			ISSUE_WAIT_W: begin
				if (wready_i) begin
					state_next = ISSUE_IDLE;
				end
			end
			ISSUE_SEND_AR: begin
				if (arready_i) begin
					state_next = ISSUE_IDLE;
				end
			end
			default: begin
				state_next = ISSUE_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state <= ISSUE_IDLE;
		end
		else begin
			state <= state_next;
		end
	end

	always_ff @(posedge clk_i) begin
		if (take_o) begin
			axi_addr <= hold_addr_i;
			wdata    <= hold_wdata_i;
			wstrb    <= hold_be_i;
		end
	end

	// Valids decoded from state, so they hold until accepted
	assign awvalid_o = (state == ISSUE_SEND_AW_W) || (state == ISSUE_WAIT_AW);
	assign wvalid_o  = (state == ISSUE_SEND_AW_W) || (state == ISSUE_WAIT_W);
	assign arvalid_o = (state == ISSUE_SEND_AR);

	assign axi_addr_o = axi_addr;
	assign wdata_o    = wdata;
	assign wstrb_o    = wstrb;

endmodule

// File: hdl/obi_req_stage.sv
`timescale 1ns/1ps

module obi_req_stage
	import bus_pkg::*;
#(
	parameter int ADDR_WIDTH = bus_pkg::ADDR_WIDTH,
	parameter int DATA_WIDTH = bus_pkg::DATA_WIDTH
) (
	input  logic  clk_i,
	input  logic  rst_n_i,

	input  logic  req_i,
	output logic  gnt_o,
	input  addr_t addr_i,
	input  logic  we_i,
	input  strb_t be_i,
	input  data_t wdata_i,

	input  logic  pause_i,

	output logic  hold_valid_o,
	input  logic  take_i,
	output addr_t hold_addr_o,
	output logic  hold_we_o,
	output strb_t hold_be_o,
	output data_t hold_wdata_o
);

	localparam int LANES = DATA_WIDTH / 8;

	// AXI-lite sees word addresses, the lanes are selected by the strobes
	localparam logic [ADDR_WIDTH-1:0] ALIGN_MASK = ~(ADDR_WIDTH'(LANES - 1));

	logic  hold_valid;
	addr_t hold_addr;
	logic  hold_we;
	strb_t hold_be;
	data_t hold_wdata;
	logic  accept;

	// Slot empty, or handed to the issue stage this cycle
	assign gnt_o  = rst_n_i && (!hold_valid || take_i) && !pause_i;
	assign accept = req_i && gnt_o;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			hold_valid <= 1'b0;
		end
		else if (accept) begin
			hold_valid <= 1'b1;
		end
		else if (take_i) begin
			hold_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept) begin
			hold_addr <= addr_i & ALIGN_MASK;
			hold_we   <= we_i;
			hold_be   <= be_i;

			// Disabled byte lanes are cleared
			for (int i = 0; i < LANES; i++) begin
				hold_wdata[8*i +: 8] <= be_i[i] ? wdata_i[8*i +: 8] : 8'h00;
			end
		end
	end

	assign hold_valid_o = hold_valid;
	assign hold_addr_o  = hold_addr;
	assign hold_we_o    = hold_we;
	assign hold_be_o    = hold_be;
	assign hold_wdata_o = hold_wdata;

endmodule

// File: hdl/bus_pkg.sv
package bus_pkg;

	// Default bus geometry, overridden through module parameters
	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;
	localparam int STRB_WIDTH = DATA_WIDTH / 8;

	// Byte address
	typedef logic [ADDR_WIDTH-1:0] addr_t;

	// One data word
	typedef logic [DATA_WIDTH-1:0] data_t;

	// One enable bit per data byte
	typedef logic [STRB_WIDTH-1:0] strb_t;

	// Issue stage FSM
	typedef enum logic [2:0] {
		ISSUE_IDLE,
		ISSUE_SEND_AW_W,
		ISSUE_WAIT_AW,
		ISSUE_WAIT_W,
		ISSUE_SEND_AR
	} issue_state_e;

endpackage
